// File: source/lsuPkg.sv
package lsuPkg;

    // datapath widths
    parameter int DataWidth    = 64;
    parameter int MaskWidth    = 8;
    parameter int RegAddrWidth = 5;
    parameter int Funct3Width  = 3;

    // load funct3 codes
    parameter logic [Funct3Width-1:0] FunctLb  = 3'd0;
    parameter logic [Funct3Width-1:0] FunctLh  = 3'd1;
    parameter logic [Funct3Width-1:0] FunctLw  = 3'd2;
    parameter logic [Funct3Width-1:0] FunctLd  = 3'd3;
    parameter logic [Funct3Width-1:0] FunctLbu = 3'd4;
    parameter logic [Funct3Width-1:0] FunctLhu = 3'd5;
    parameter logic [Funct3Width-1:0] FunctLwu = 3'd6;

    // address bits 31:28 of main memory
    parameter logic [3:0] MemRegionTag = 4'h8;

    // single beat of 8 bytes, incrementing burst
    parameter logic [2:0] BusSize  = 3'd3;
    parameter logic [1:0] BusBurst = 2'b01;
    parameter logic [7:0] BusLen   = 8'd0;

    // result entry layout, lsb first
    parameter int SkipRefPos     = 0;
    parameter int LoadPos        = 1;
    parameter int WriteEnablePos = 2;
    parameter int DestinationLsb = 3;
    parameter int Funct3Lsb      = DestinationLsb + RegAddrWidth;
    parameter int DataLsb        = Funct3Lsb + Funct3Width;
    parameter int AddressLsb     = DataLsb + DataWidth;
    parameter int PcLsb          = AddressLsb + DataWidth;
    parameter int ResultWidth    = PcLsb + DataWidth;

endpackage

// File: source/memRequestIssuer.sv
`timescale 1ns/1ns
module memRequestIssuer #(
    parameter int EntryWidth = lsuPkg::ResultWidth
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              reqValid,
    output logic                              reqReady,
    input  logic [lsuPkg::DataWidth-1:0]      reqPc,
    input  logic [lsuPkg::DataWidth-1:0]      reqAddress,
    input  logic [lsuPkg::DataWidth-1:0]      reqWriteData,
    input  logic [lsuPkg::MaskWidth-1:0]      reqWriteMask,
    input  logic [lsuPkg::Funct3Width-1:0]    reqFunct3,
    input  logic                              reqLoad,
    input  logic                              reqStore,
    input  logic [lsuPkg::RegAddrWidth-1:0]   reqDestination,
    input  logic                              reqWriteEnable,
    output logic                              arValid,
    input  logic                              arReady,
    output logic [lsuPkg::DataWidth-1:0]      arAddress,
    output logic [2:0]                        arSize,
    output logic [1:0]                        arBurst,
    output logic [7:0]                        arLen,
    input  logic                              rValid,
    output logic                              rReady,
    input  logic [lsuPkg::DataWidth-1:0]      rData,
    output logic                              awValid,
    input  logic                              awReady,
    output logic [lsuPkg::DataWidth-1:0]      awAddress,
    output logic [2:0]                        awSize,
    output logic [1:0]                        awBurst,
    output logic [7:0]                        awLen,
    output logic                              wValid,
    input  logic                              wReady,
    output logic [lsuPkg::DataWidth-1:0]      wData,
    output logic [lsuPkg::MaskWidth-1:0]      wStrobe,
    output logic                              wLast,
    output logic                              pushValid,
    input  logic                              pushReady,
    output logic [EntryWidth-1:0]             pushEntry
);
    import lsuPkg::*;

    localparam logic [2:0] StateIdle      = 3'd0;
    localparam logic [2:0] StateAddrWait  = 3'd1;
    localparam logic [2:0] StateReadData  = 3'd2;
    localparam logic [2:0] StateWriteData = 3'd3;
    localparam logic [2:0] StateDone      = 3'd4;

    logic [2:0]              state;
    logic [DataWidth-1:0]    capPc;
    logic [DataWidth-1:0]    capAddress;
    logic [DataWidth-1:0]    capWriteData;
    logic [DataWidth-1:0]    capData;
    logic [MaskWidth-1:0]    capWriteMask;
    logic [Funct3Width-1:0]  capFunct3;
    logic [RegAddrWidth-1:0] capDestination;
    logic                    capWriteEnable;
    logic                    capLoad;
    logic                    capStore;
    logic                    accept;
    logic                    reqMain;
    logic                    capMain;
    logic                    capSkipRef;

    assign accept  = reqValid && reqReady;
    assign reqMain = reqAddress[31:28] == MemRegionTag;
    assign capMain = capAddress[31:28] == MemRegionTag;
    // device space never reaches the bus
    assign capSkipRef = (capLoad || capStore) && !capMain;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= StateIdle;
        end else begin
            case (state)
                StateIdle: begin
                    if (accept) begin
                        if ((reqLoad || reqStore) && reqMain) begin
                            state <= StateAddrWait;
                        end else begin
                            state <= StateDone;
                        end
                    end
                end
                StateAddrWait: begin
                    if (arValid && arReady) begin
                        state <= StateReadData;
                    end else if (awValid && awReady) begin
                        state <= StateWriteData;
                    end
                end
                StateReadData: begin
                    if (rValid) begin
                        state <= StateDone;
                    end
                end
                StateWriteData: begin
                    if (wReady) begin
                        state <= StateDone;
                    end
                end
                StateDone: begin
                    if (pushReady) begin
                        state <= StateIdle;
                    end
                end
                default: begin
                    state <= StateIdle;
                end
            endcase
        end
    end

    // request capture and read data
    always_ff @(posedge clock) begin
        if (accept) begin
            capPc          <= reqPc;
            capAddress     <= reqAddress;
            capWriteData   <= reqWriteData;
            capWriteMask   <= reqWriteMask;
            capFunct3      <= reqFunct3;
            capLoad        <= reqLoad;
            capStore       <= reqStore;
            capDestination <= reqDestination;
            capWriteEnable <= reqWriteEnable;
            capData        <= '0;
        end else if (rValid && rReady) begin
            capData <= rData;
        end
    end

    assign reqReady = state == StateIdle;

    // a request flagged as both load and store is treated as a load
    assign arValid   = (state == StateAddrWait) && capLoad;
    assign arAddress = capAddress;
    assign arSize    = BusSize;
    assign arBurst   = BusBurst;
    assign arLen     = BusLen;
    assign rReady    = state == StateReadData;

    assign awValid   = (state == StateAddrWait) && capStore && !capLoad;
    assign awAddress = capAddress;
    assign awSize    = BusSize;
    assign awBurst   = BusBurst;
    assign awLen     = BusLen;
    // store data already sits in its byte lanes
    assign wValid    = state == StateWriteData;
    assign wData     = capWriteData;
    assign wStrobe   = capWriteMask;
    assign wLast     = 1'b1;

    assign pushValid = state == StateDone;
    assign pushEntry = {capPc, capAddress, capData, capFunct3, capDestination,
                        capWriteEnable, capLoad, capSkipRef};

    arHeld: assert property (@(posedge clock) disable iff (reset)
        arValid && !arReady |=> arValid && $stable(arAddress));
    awHeld: assert property (@(posedge clock) disable iff (reset)
        awValid && !awReady |=> awValid && $stable(awAddress));
    oneChannel: assert property (@(posedge clock) disable iff (reset)
        !(arValid && awValid));

endmodule

// File: source/lsuResultQueue.sv
`timescale 1ns/1ns
module lsuResultQueue #(
    parameter int EntryWidth = lsuPkg::ResultWidth,
    parameter int QueueDepth = 2
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  pushValid,
    output logic                  pushReady,
    input  logic [EntryWidth-1:0] pushEntry,
    output logic                  popValid,
    input  logic                  popReady,
    output logic [EntryWidth-1:0] popEntry
);

    localparam int PtrWidth   = $clog2(QueueDepth);
    localparam int CountWidth = $clog2(QueueDepth + 1);
    localparam logic [CountWidth-1:0] FullCount = CountWidth'(QueueDepth);

    logic [EntryWidth-1:0] entries [QueueDepth];
    logic [PtrWidth-1:0]   writePtr;
    logic [PtrWidth-1:0]   readPtr;
    logic [CountWidth-1:0] count;
    logic                  doPush;
    logic                  doPop;

    assign pushReady = count != FullCount;
    assign popValid  = count != '0;
    assign popEntry  = entries[readPtr];

    assign doPush = pushValid && pushReady;
    assign doPop  = popValid && popReady;

    // pointers wrap naturally since the depth is a power of two
    always_ff @(posedge clock) begin
        if (reset) begin
            writePtr <= '0;
            readPtr  <= '0;
            count    <= '0;
        end else begin
            if (doPush) begin
                writePtr <= writePtr + 1'b1;
            end
            if (doPop) begin
                readPtr <= readPtr + 1'b1;
            end
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (doPush) begin
            entries[writePtr] <= pushEntry;
        end
    end

    // a push offered to a full queue must wait, unchanged, for space
    fullStall: assert property (@(posedge clock) disable iff (reset)
        pushValid && count == FullCount |=> pushValid && $stable(pushEntry));
    noOverflow: assert property (@(posedge clock) disable iff (reset)
        count <= FullCount);

endmodule

// File: source/loadResultFormatter.sv
`timescale 1ns/1ns
module loadResultFormatter #(
    parameter int EntryWidth = lsuPkg::ResultWidth
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              popValid,
    output logic                              popReady,
    input  logic [EntryWidth-1:0]             popEntry,
    output logic                              wbValid,
    input  logic                              wbReady,
    output logic [lsuPkg::DataWidth-1:0]      wbPc,
    output logic [lsuPkg::DataWidth-1:0]      wbAddress,
    output logic [lsuPkg::DataWidth-1:0]      wbLoadData,
    output logic [lsuPkg::RegAddrWidth-1:0]   wbDestination,
    output logic                              wbWriteEnable,
    output logic                              wbLoad,
    output logic                              wbSkipRef
);
    import lsuPkg::*;

    logic [DataWidth-1:0]   popAddress;
    logic [DataWidth-1:0]   popRaw;
    logic [Funct3Width-1:0] popFunct3;
    logic                   popLoad;
    logic [DataWidth-1:0]   shifted;
    logic [DataWidth-1:0]   extended;
    logic                   doPop;

    assign popAddress = popEntry[AddressLsb +: DataWidth];
    assign popRaw     = popEntry[DataLsb +: DataWidth];
    assign popFunct3  = popEntry[Funct3Lsb +: Funct3Width];
    assign popLoad    = popEntry[LoadPos];

    // bring the addressed byte lane down to bit 0
    assign shifted = popRaw >> {popAddress[2:0], 3'b000};

    always_comb begin
        case (popFunct3)
            FunctLb:  extended = {{(DataWidth - 8){shifted[7]}}, shifted[7:0]};
            FunctLh:  extended = {{(DataWidth - 16){shifted[15]}}, shifted[15:0]};
            FunctLw:  extended = {{(DataWidth - 32){shifted[31]}}, shifted[31:0]};
            FunctLd:  extended = shifted;
            FunctLbu: extended = {{(DataWidth - 8){1'b0}}, shifted[7:0]};
            FunctLhu: extended = {{(DataWidth - 16){1'b0}}, shifted[15:0]};
            FunctLwu: extended = {{(DataWidth - 32){1'b0}}, shifted[31:0]};
            default:  extended = shifted;
        endcase
        if (!popLoad) begin
            extended = '0;
        end
    end

    assign popReady = !wbValid || wbReady;
    assign doPop    = popValid && popReady;

    always_ff @(posedge clock) begin
        if (reset) begin
            wbValid <= 1'b0;
        end else if (doPop) begin
            wbValid <= 1'b1;
        end else if (wbReady) begin
            wbValid <= 1'b0;
        end
    end

    // output register, held while writeback stalls
    always_ff @(posedge clock) begin
        if (doPop) begin
            wbPc          <= popEntry[PcLsb +: DataWidth];
            wbAddress     <= popAddress;
            wbLoadData    <= extended;
            wbDestination <= popEntry[DestinationLsb +: RegAddrWidth];
            wbWriteEnable <= popEntry[WriteEnablePos];
            wbLoad        <= popLoad;
            wbSkipRef     <= popEntry[SkipRefPos];
        end
    end

    wbStable: assert property (@(posedge clock) disable iff (reset)
        wbValid && !wbReady |=> wbValid && $stable(wbPc) && $stable(wbAddress)
            && $stable(wbLoadData) && $stable(wbDestination) && $stable(wbWriteEnable)
            && $stable(wbLoad) && $stable(wbSkipRef));

endmodule

// File: source/loadStoreUnit.sv
`timescale 1ns/1ns
module loadStoreUnit #(
    parameter int QueueDepth = 2,
    parameter int EntryWidth = lsuPkg::ResultWidth
) (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              reqValid,
    output logic                              reqReady,
    input  logic [lsuPkg::DataWidth-1:0]      reqPc,
    input  logic [lsuPkg::DataWidth-1:0]      reqAddress,
    input  logic [lsuPkg::DataWidth-1:0]      reqWriteData,
    input  logic [lsuPkg::MaskWidth-1:0]      reqWriteMask,
    input  logic [lsuPkg::Funct3Width-1:0]    reqFunct3,
    input  logic                              reqLoad,
    input  logic                              reqStore,
    input  logic [lsuPkg::RegAddrWidth-1:0]   reqDestination,
    input  logic                              reqWriteEnable,
    output logic                              arValid,
    input  logic                              arReady,
    output logic [lsuPkg::DataWidth-1:0]      arAddress,
    output logic [2:0]                        arSize,
    output logic [1:0]                        arBurst,
    output logic [7:0]                        arLen,
    input  logic                              rValid,
    output logic                              rReady,
    input  logic [lsuPkg::DataWidth-1:0]      rData,
    output logic                              awValid,
    input  logic                              awReady,
    output logic [lsuPkg::DataWidth-1:0]      awAddress,
    output logic [2:0]                        awSize,
    output logic [1:0]                        awBurst,
    output logic [7:0]                        awLen,
    output logic                              wValid,
    input  logic                              wReady,
    output logic [lsuPkg::DataWidth-1:0]      wData,
    output logic [lsuPkg::MaskWidth-1:0]      wStrobe,
    output logic                              wLast,
    output logic                              wbValid,
    input  logic                              wbReady,
    output logic [lsuPkg::DataWidth-1:0]      wbPc,
    output logic [lsuPkg::DataWidth-1:0]      wbAddress,
    output logic [lsuPkg::DataWidth-1:0]      wbLoadData,
    output logic [lsuPkg::RegAddrWidth-1:0]   wbDestination,
    output logic                              wbWriteEnable,
    output logic                              wbLoad,
    output logic                              wbSkipRef
);

    logic                  pushValid;
    logic                  pushReady;
    logic [EntryWidth-1:0] pushEntry;
    logic                  popValid;
    logic                  popReady;
    logic [EntryWidth-1:0] popEntry;

    memRequestIssuer #(
        .EntryWidth(EntryWidth)
    ) issuer (
        .clock(clock), .reset(reset),
        .reqValid(reqValid), .reqReady(reqReady), .reqPc(reqPc),
        .reqAddress(reqAddress), .reqWriteData(reqWriteData),
        .reqWriteMask(reqWriteMask), .reqFunct3(reqFunct3),
        .reqLoad(reqLoad), .reqStore(reqStore),
        .reqDestination(reqDestination), .reqWriteEnable(reqWriteEnable),
        .arValid(arValid), .arReady(arReady), .arAddress(arAddress),
        .arSize(arSize), .arBurst(arBurst), .arLen(arLen),
        .rValid(rValid), .rReady(rReady), .rData(rData),
        .awValid(awValid), .awReady(awReady), .awAddress(awAddress),
        .awSize(awSize), .awBurst(awBurst), .awLen(awLen),
        .wValid(wValid), .wReady(wReady), .wData(wData),
        .wStrobe(wStrobe), .wLast(wLast),
        .pushValid(pushValid), .pushReady(pushReady), .pushEntry(pushEntry)
    );

    lsuResultQueue #(
        .EntryWidth(EntryWidth),
        .QueueDepth(QueueDepth)
    ) resultQueue (
        .clock(clock), .reset(reset),
        .pushValid(pushValid), .pushReady(pushReady), .pushEntry(pushEntry),
        .popValid(popValid), .popReady(popReady), .popEntry(popEntry)
    );

    loadResultFormatter #(
        .EntryWidth(EntryWidth)
    ) formatter (
        .clock(clock), .reset(reset),
        .popValid(popValid), .popReady(popReady), .popEntry(popEntry),
        .wbValid(wbValid), .wbReady(wbReady), .wbPc(wbPc),
        .wbAddress(wbAddress), .wbLoadData(wbLoadData),
        .wbDestination(wbDestination), .wbWriteEnable(wbWriteEnable),
        .wbLoad(wbLoad), .wbSkipRef(wbSkipRef)
    );

endmodule

// File: testbench/lsuMemoryModel.sv
`timescale 1ns/1ns
module lsuMemoryModel (
    input  logic        clock,
    input  logic        reset,
    input  logic        arValid,
    output logic        arReady,
    input  logic [63:0] arAddress,
    output logic        rValid,
    input  logic        rReady,
    output logic [63:0] rData,
    input  logic        awValid,
    output logic        awReady,
    input  logic [63:0] awAddress,
    input  logic        wValid,
    output logic        wReady,
    input  logic [63:0] wData,
    input  logic [7:0]  wStrobe
);

    logic [63:0] mem [128];
    logic [6:0]  readIndex;
    logic [6:0]  writeIndex;
    logic        readPending;
    logic [1:0]  delay;
    integer      seed;
    integer      randomBits;
    integer      b;

    initial begin
        seed = 32'h2dc6c134;
    end

    // one transfer at a time, each followed by a random gap of 0 to 3 cycles
    always @(posedge clock) begin
        randomBits = $random(seed);
        if (reset) begin
            arReady     <= 1'b0;
            awReady     <= 1'b0;
            wReady      <= 1'b0;
            rValid      <= 1'b0;
            rData       <= '0;
            readPending <= 1'b0;
            delay       <= '0;
            for (b = 0; b < 128; b = b + 1) begin
                mem[b] <= '0;
            end
        end else begin
            arReady <= 1'b0;
            awReady <= 1'b0;
            wReady  <= 1'b0;
            if (rValid && rReady) begin
                rValid <= 1'b0;
            end
            // byte lanes written on the w handshake
            if (wValid && wReady) begin
                for (b = 0; b < 8; b = b + 1) begin
                    if (wStrobe[b]) begin
                        mem[writeIndex][b*8 +: 8] <= wData[b*8 +: 8];
                    end
                end
            end
            if (delay != 2'd0) begin
                delay <= delay - 2'd1;
            end else if (arValid && !arReady) begin
                arReady     <= 1'b1;
                readIndex   <= arAddress[9:3];
                readPending <= 1'b1;
                delay       <= randomBits[1:0];
            end else if (readPending && !rValid && !arReady) begin
                rValid      <= 1'b1;
                rData       <= mem[readIndex];
                readPending <= 1'b0;
                delay       <= randomBits[1:0];
            end else if (awValid && !awReady) begin
                awReady    <= 1'b1;
                writeIndex <= awAddress[9:3];
                delay      <= randomBits[1:0];
            end else if (wValid && !wReady) begin
                wReady <= 1'b1;
                delay  <= randomBits[1:0];
            end
        end
    end

endmodule

// File: testbench/lsuTb.sv
`timescale 1ns/1ns
module lsuTb;
    import lsuPkg::*;

    logic        clock;
    logic        reset;
    logic        reqValid;
    logic        reqReady;
    logic [63:0] reqPc;
    logic [63:0] reqAddress;
    logic [63:0] reqWriteData;
    logic [7:0]  reqWriteMask;
    logic [2:0]  reqFunct3;
    logic        reqLoad;
    logic        reqStore;
    logic [4:0]  reqDestination;
    logic        reqWriteEnable;
    logic        arValid, arReady, rValid, rReady;
    logic        awValid, awReady, wValid, wReady, wLast;
    logic [63:0] arAddress, awAddress, rData, wData;
    logic [2:0]  arSize, awSize;
    logic [1:0]  arBurst, awBurst;
    logic [7:0]  arLen, awLen, wStrobe;
    logic        wbValid, wbReady, wbWriteEnable, wbLoad, wbSkipRef;
    logic [63:0] wbPc, wbAddress, wbLoadData;
    logic [4:0]  wbDestination;

    // trace columns
    logic [63:0] tKind [64];
    logic [63:0] tFunct3 [64];
    logic [63:0] tAddress [64];
    logic [63:0] tWriteData [64];
    logic [63:0] tMask [64];
    logic [63:0] tDestination [64];
    logic [63:0] tWriteEnable [64];
    logic [63:0] tPc [64];
    logic [63:0] tLoadData [64];
    logic [63:0] tSkipRef [64];
    int          lineCount;
    int          expectQ [$];
    int          errorCount;
    integer      seed;
    integer      randomBits;
    logic        stallPrev;
    logic [63:0] prevPc;
    logic [199:0] prevPayload;
    logic [199:0] wbPayload;

    loadStoreUnit dut (.*);

    lsuMemoryModel memory (
        .clock(clock), .reset(reset),
        .arValid(arValid), .arReady(arReady), .arAddress(arAddress),
        .rValid(rValid), .rReady(rReady), .rData(rData),
        .awValid(awValid), .awReady(awReady), .awAddress(awAddress),
        .wValid(wValid), .wReady(wReady), .wData(wData), .wStrobe(wStrobe)
    );

    // whole writeback payload, for the stall check
    assign wbPayload = {wbPc, wbAddress, wbLoadData, wbDestination,
                        wbWriteEnable, wbLoad, wbSkipRef};

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic readTrace();
        integer fd;
        integer n;
        logic [8*256-1:0] line;
        fd = $fopen("testbench/lsuTrace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            errorCount++;
            return;
        end
        while (!$feof(fd) && lineCount < 64) begin
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", tKind[lineCount],
                tFunct3[lineCount], tAddress[lineCount], tWriteData[lineCount],
                tMask[lineCount], tDestination[lineCount], tWriteEnable[lineCount],
                tPc[lineCount], tLoadData[lineCount], tSkipRef[lineCount]);
            // comment and blank lines scan nothing
            if (n == 10) begin
                lineCount++;
            end
        end
        $fclose(fd);
    endtask

    task automatic compareField(input string name, input logic [63:0] got,
                                input logic [63:0] expected);
        if (got !== expected) begin
            errorCount++;
            $display("ERR %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic sendRequest(input int i);
        reqValid       <= 1'b1;
        reqPc          <= tPc[i];
        reqAddress     <= tAddress[i];
        reqWriteData   <= tWriteData[i];
        reqWriteMask   <= tMask[i][7:0];
        reqFunct3      <= tFunct3[i][2:0];
        reqLoad        <= tKind[i] == 64'd1;
        reqStore       <= tKind[i] == 64'd2;
        reqDestination <= tDestination[i][4:0];
        reqWriteEnable <= tWriteEnable[i][0];
        do begin
            @(posedge clock);
        end while (!reqReady);
        expectQ.push_back(i);
    endtask

    // writeback scoreboard and bus monitors
    always @(posedge clock) begin
        int i;
        randomBits = $random(seed);
        wbReady <= randomBits[1:0] != 2'b00;
        if (!reset) begin
            if (arValid && arAddress[31:28] != MemRegionTag) begin
                errorCount++;
                $display("read address channel active for device address %h", arAddress);
            end
            if (awValid && awAddress[31:28] != MemRegionTag) begin
                errorCount++;
                $display("write address channel active for device address %h", awAddress);
            end
            // single beat of 8 bytes, incrementing burst
            if (arValid) begin
                compareField("arSize", 64'(arSize), 64'd3);
                compareField("arBurst", 64'(arBurst), 64'd1);
                compareField("arLen", 64'(arLen), 64'd0);
            end
            if (awValid) begin
                compareField("awSize", 64'(awSize), 64'd3);
                compareField("awBurst", 64'(awBurst), 64'd1);
                compareField("awLen", 64'(awLen), 64'd0);
            end
            if (wValid) begin
                compareField("wLast", 64'(wLast), 64'd1);
            end
            if (stallPrev && (!wbValid || wbPayload !== prevPayload)) begin
                errorCount++;
                $display("writeback output changed while stalled at pc %h", prevPc);
            end
            if (wbValid && wbReady) begin
                if (expectQ.size() == 0) begin
                    errorCount++;
                    $display("writeback result with nothing expected, pc %h", wbPc);
                end else begin
                    i = expectQ.pop_front();
                    compareField("wbPc", wbPc, tPc[i]);
                    compareField("wbAddress", wbAddress, tAddress[i]);
                    compareField("wbLoadData", wbLoadData, tLoadData[i]);
                    compareField("wbDestination", 64'(wbDestination), tDestination[i]);
                    compareField("wbWriteEnable", 64'(wbWriteEnable), tWriteEnable[i]);
                    compareField("wbLoad", 64'(wbLoad), 64'(tKind[i] == 64'd1));
                    compareField("wbSkipRef", 64'(wbSkipRef), tSkipRef[i]);
                end
            end
        end
        stallPrev   = !reset && wbValid && !wbReady;
        prevPc      = wbPc;
        prevPayload = wbPayload;
    end

    // watchdog allows 20 cycles per trace line
    initial begin
        wait (lineCount > 0);
        #(lineCount * 20 * 40);
        $display("timeout, %0d results still outstanding", expectQ.size());
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        seed           = 32'h2dc6c134;
        errorCount     = 0;
        lineCount      = 0;
        stallPrev      = 1'b0;
        reset          = 1'b1;
        reqValid       = 1'b0;
        reqPc          = '0;
        reqAddress     = '0;
        reqWriteData   = '0;
        reqWriteMask   = '0;
        reqFunct3      = '0;
        reqLoad        = 1'b0;
        reqStore       = 1'b0;
        reqDestination = '0;
        reqWriteEnable = 1'b0;
        wbReady        = 1'b0;
        readTrace();
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        if (wbValid || arValid || awValid || !reqReady) begin
            errorCount++;
            $display("outputs not in their reset state after reset");
        end
        for (int i = 0; i < lineCount; i++) begin
            sendRequest(i);
        end
        reqValid <= 1'b0;
        while (expectQ.size() != 0) begin
            @(posedge clock);
        end
        repeat (2) @(posedge clock);
        $display("%0d errors over %0d trace lines", errorCount, lineCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: testbench/lsuTrace.txt
# kind(0 other,1 load,2 store) funct3 address wdata mask dest we pc expLoadData expSkipRef
# all values hex
2 3 80000000 f0e1d2c3b4a59687 ff 00 0 1000 0 0
1 0 80000000 0 0 05 1 1004 ffffffffffffff87 0
1 4 80000000 0 0 06 1 1008 87 0
1 1 80000002 0 0 07 1 100c ffffffffffffb4a5 0
1 5 80000006 0 0 08 1 1010 f0e1 0
1 2 80000004 0 0 09 1 1014 fffffffff0e1d2c3 0
1 6 80000000 0 0 0a 1 1018 b4a59687 0
1 3 80000000 0 0 0b 1 101c f0e1d2c3b4a59687 0
2 3 80000008 1122334455667788 0f 00 0 1020 0 0
2 3 8000000c 00007f0100000000 30 00 0 1024 0 0
1 3 80000008 0 0 0c 1 1028 00007f0155667788 0
1 1 8000000c 0 0 0d 1 102c 7f01 0
1 0 80000009 0 0 0e 1 1030 77 0
1 2 80000008 0 0 0f 1 1034 55667788 0
1 3 10000000 0 0 10 1 1038 0 1
2 3 20000040 deadbeefdeadbeef ff 00 0 103c 0 1
1 3 80000040 0 0 11 1 1040 0 0
0 0 00001234 0 0 12 1 1044 0 0
0 7 7fff0000 0 0 13 0 1048 0 0
1 5 90000010 0 0 14 1 104c 0 1

// File: flist.f
source/lsuPkg.sv
source/memRequestIssuer.sv
source/lsuResultQueue.sv
source/loadResultFormatter.sv
source/loadStoreUnit.sv
testbench/lsuMemoryModel.sv
testbench/lsuTb.sv

// File: run.sh
#!/bin/sh
# build and run the load/store unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module lsuTb -f flist.f -o lsuSim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/lsuSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Simulation PASSED$"; then
    exit 0
fi
exit 1
